//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // memory opcodes, same order as the CPU decode
    typedef enum logic [2:0] {
        LDB  = 3'd0,
        LDH  = 3'd1,
        LDW  = 3'd2,
        LDBU = 3'd3,
        LDHU = 3'd4,
        STB  = 3'd5,
        STH  = 3'd6,
        STW  = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        S_IDLE, // ready for a request
        S_WAIT, // cache access outstanding
        S_RESP  // response on the CPU side
    } stage_state_e;

    typedef enum logic [1:0] {
        C_IDLE,
        C_HIT,  // hit data in rdata
        C_BUS,  // wishbone cycle open
        C_DONE
    } cache_state_e;

    // direct-mapped cache, one word per line
    localparam int LINE_COUNT = 16;
    localparam int INDEX_W    = 4;  // byte address 5:2
    localparam int TAG_W      = 26; // byte address 31:6

    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = 8;  // word address, byte address 9:2

endpackage

`default_nettype wire

//--- source/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_if;
    logic        valid; // request present
    logic        we;    // store
    logic [31:0] addr;  // byte address
    logic [3:0]  wstrb; // byte enables
    logic [31:0] wdata; // already in its byte lanes
    logic        done;  // one-cycle completion pulse
    logic [31:0] rdata; // full aligned word

    modport stage (
        output valid, we, addr, wstrb, wdata,
        input  done, rdata
    );

    modport cache (
        input  valid, we, addr, wstrb, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      req_valid,
    input  wire lsu_pkg::mem_op_e    req_op,
    input  wire  [31:0]              req_base,
    input  wire  [31:0]              req_imm,
    input  wire  [31:0]              req_wdata,
    input  wire  [5:0]               req_rd,
    output logic                     req_ready,
    output logic                     resp_valid,
    output logic                     resp_err,
    output logic [5:0]               resp_rd,
    output logic [31:0]              resp_data,
    dcache_if.stage                  mem
);

    lsu_pkg::stage_state_e state;
    lsu_pkg::mem_op_e      op_q;     // opcode kept for the return path
    logic [1:0]            lo_q;     // byte offset in the word
    logic [31:0]           eff_addr;
    logic                  misaligned;
    logic                  is_store;
    logic [3:0]            strb;
    logic [31:0]           lane_data;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    logic [31:0]           load_data;

    assign eff_addr   = req_base + req_imm;
    assign req_ready  = (state == lsu_pkg::S_IDLE);
    assign resp_valid = (state == lsu_pkg::S_RESP);
    assign is_store   = (req_op == lsu_pkg::STB) || (req_op == lsu_pkg::STH) ||
                        (req_op == lsu_pkg::STW);

    // alignment check, byte lane enables and store data lanes
    always_comb begin
        misaligned = 1'b0;
        strb       = 4'b0000;
        lane_data  = req_wdata;
        case (req_op)
            lsu_pkg::LDH, lsu_pkg::LDHU: misaligned = eff_addr[0];
            lsu_pkg::LDW:                misaligned = |eff_addr[1:0];
            lsu_pkg::STB: begin
                strb      = 4'b0001 << eff_addr[1:0];
                lane_data = {4{req_wdata[7:0]}};
            end
            lsu_pkg::STH: begin
                misaligned = eff_addr[0];
                strb       = eff_addr[1] ? 4'b1100 : 4'b0011;
                lane_data  = {2{req_wdata[15:0]}};
            end
            lsu_pkg::STW: begin
                misaligned = |eff_addr[1:0];
                strb       = 4'b1111;
            end
            default: ;
        endcase
    end

    // pick the addressed byte or halfword out of the returned word
    assign ld_byte = mem.rdata[{lo_q, 3'b000} +: 8];
    assign ld_half = lo_q[1] ? mem.rdata[31:16] : mem.rdata[15:0];

    always_comb begin
        case (op_q)
            lsu_pkg::LDB:  load_data = {{24{ld_byte[7]}}, ld_byte};
            lsu_pkg::LDH:  load_data = {{16{ld_half[15]}}, ld_half};
            lsu_pkg::LDW:  load_data = mem.rdata;
            lsu_pkg::LDBU: load_data = {24'd0, ld_byte};
            lsu_pkg::LDHU: load_data = {16'd0, ld_half};
            default:       load_data = 32'd0; // stores return zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= lsu_pkg::S_IDLE;
            mem.valid <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::S_IDLE: begin
                    if (req_valid) begin
                        if (misaligned) begin
                            state <= lsu_pkg::S_RESP; // answered without the cache
                        end else begin
                            state     <= lsu_pkg::S_WAIT;
                            mem.valid <= 1'b1;
                        end
                    end
                end
                lsu_pkg::S_WAIT: begin
                    if (mem.done) begin
                        state     <= lsu_pkg::S_RESP;
                        mem.valid <= 1'b0;
                    end
                end
                lsu_pkg::S_RESP: state <= lsu_pkg::S_IDLE;
                default:         state <= lsu_pkg::S_IDLE;
            endcase
        end
    end

    // request fields held for the cache, response fields for the CPU
    always_ff @(posedge clk) begin
        if (req_ready && req_valid) begin
            mem.we    <= is_store;
            mem.addr  <= eff_addr;
            mem.wstrb <= strb;
            mem.wdata <= lane_data;
            op_q      <= req_op;
            lo_q      <= eff_addr[1:0];
            resp_rd   <= req_rd;
            resp_err  <= misaligned;
            resp_data <= 32'd0;
        end else if (state == lsu_pkg::S_WAIT && mem.done) begin
            resp_data <= load_data;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire                              clk,
    input  wire                              rstn,
    dcache_if.cache                          mem,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [lsu_pkg::RAM_ADDR_W-1:0]   wb_adr,
    output logic [3:0]                       wb_sel,
    output logic [31:0]                      wb_dat_w,
    input  wire  [31:0]                      wb_dat_r,
    input  wire                              wb_ack
);

    lsu_pkg::cache_state_e             state;
    logic [lsu_pkg::LINE_COUNT-1:0]    line_valid;
    logic [lsu_pkg::TAG_W-1:0]         tag_mem  [lsu_pkg::LINE_COUNT];
    logic [31:0]                       data_mem [lsu_pkg::LINE_COUNT];
    logic [lsu_pkg::INDEX_W-1:0]       idx;
    logic [lsu_pkg::TAG_W-1:0]         tag;
    logic                              hit;
    logic                              bus_ack;

    assign idx = mem.addr[lsu_pkg::INDEX_W+1:2];
    assign tag = mem.addr[31:32-lsu_pkg::TAG_W];
    assign hit = line_valid[idx] && (tag_mem[idx] == tag);

    assign mem.done = (state == lsu_pkg::C_HIT) || (state == lsu_pkg::C_DONE);

    // bus fields come straight from the held request
    assign wb_cyc   = (state == lsu_pkg::C_BUS);
    assign wb_stb   = wb_cyc;
    assign wb_we    = mem.we;
    assign wb_adr   = mem.addr[lsu_pkg::RAM_ADDR_W+1:2];
    assign wb_sel   = mem.we ? mem.wstrb : 4'b1111; // reads fetch the whole word
    assign wb_dat_w = mem.wdata;
    assign bus_ack  = wb_cyc && wb_ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= lsu_pkg::C_IDLE;
            line_valid <= '0;
        end else begin
            case (state)
                lsu_pkg::C_IDLE: begin
                    if (mem.valid) begin
                        if (!mem.we && hit) begin
                            state <= lsu_pkg::C_HIT;
                        end else begin
                            state <= lsu_pkg::C_BUS; // miss or store
                        end
                    end
                end
                lsu_pkg::C_HIT: state <= lsu_pkg::C_IDLE;
                lsu_pkg::C_BUS: begin
                    if (bus_ack) begin
                        state <= lsu_pkg::C_DONE;
                        if (!mem.we) begin
                            line_valid[idx] <= 1'b1; // fill complete
                        end
                    end
                end
                lsu_pkg::C_DONE: state <= lsu_pkg::C_IDLE;
                default:         state <= lsu_pkg::C_IDLE;
            endcase
        end
    end

    // line storage and read data
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::C_IDLE && mem.valid && !mem.we && hit) begin
            mem.rdata <= data_mem[idx];
        end
        if (state == lsu_pkg::C_BUS && bus_ack) begin
            if (!mem.we) begin
                tag_mem[idx]  <= tag;
                data_mem[idx] <= wb_dat_r;
                mem.rdata     <= wb_dat_r;
            end else if (hit) begin
                // write-through hit, keep the line current
                for (int b = 0; b < 4; b++) begin
                    if (mem.wstrb[b]) begin
                        data_mem[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire  [lsu_pkg::RAM_ADDR_W-1:0]   wb_adr,
    input  wire  [3:0]                       wb_sel,
    input  wire  [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack
);

    logic [31:0] ram [lsu_pkg::RAM_WORDS];
    logic        req;

    // new request only while no ack is out, so ack never repeats
    assign req = wb_cyc && wb_stb && !wb_ack;

    initial begin
        for (int i = 0; i < lsu_pkg::RAM_WORDS; i++) begin
            ram[i] = 32'd0;
        end
    end

    always @(posedge clk) begin
        if (req && wb_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_sel[b]) begin
                    ram[wb_adr][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= ram[wb_adr]; // valid with ack
        end
    end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      req_valid,
    input  wire lsu_pkg::mem_op_e    req_op,
    input  wire  [31:0]              req_base,
    input  wire  [31:0]              req_imm,
    input  wire  [31:0]              req_wdata,
    input  wire  [5:0]               req_rd,
    output wire                      req_ready,
    output wire                      resp_valid,
    output wire  [5:0]               resp_rd,
    output wire  [31:0]              resp_data,
    output wire                      resp_err
);

    dcache_if mem_bus ();

    // wishbone between cache and RAM
    wire                            wb_cyc;
    wire                            wb_stb;
    wire                            wb_we;
    wire [lsu_pkg::RAM_ADDR_W-1:0]  wb_adr;
    wire [3:0]                      wb_sel;
    wire [31:0]                     wb_dat_w;
    wire [31:0]                     wb_dat_r;
    wire                            wb_ack;

    mem_stage mem_stage_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_imm    (req_imm),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_err   (resp_err),
        .resp_rd    (resp_rd),
        .resp_data  (resp_data),
        .mem        (mem_bus.stage)
    );

    dcache dcache_inst (
        .clk      (clk),
        .rstn     (rstn),
        .mem      (mem_bus.cache),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    wb_ram wb_ram_inst (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

//--- dv/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

    localparam int NUM_ROWS       = 26;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 16 + 40;

    logic             clk;
    logic             rstn;
    logic             req_valid;
    lsu_pkg::mem_op_e req_op;
    logic [31:0]      req_base;
    logic [31:0]      req_imm;
    logic [31:0]      req_wdata;
    logic [5:0]       req_rd;
    wire              req_ready;
    wire              resp_valid;
    wire  [5:0]       resp_rd;
    wire  [31:0]      resp_data;
    wire              resp_err;

    // stimulus table, expected columns filled from the byte model
    lsu_pkg::mem_op_e op_tab       [NUM_ROWS];
    logic [31:0]      base_tab     [NUM_ROWS];
    logic [31:0]      imm_tab      [NUM_ROWS];
    logic [31:0]      wdata_tab    [NUM_ROWS];
    logic [5:0]       rd_tab       [NUM_ROWS];
    logic [31:0]      exp_data_tab [NUM_ROWS];
    logic             exp_err_tab  [NUM_ROWS];

    logic [7:0]  model_mem [1024]; // byte view of the RAM, starts at zero
    logic [31:0] lfsr_state;
    int          row_count;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    lsu_top lsu_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_imm    (req_imm),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rd    (resp_rd),
        .resp_data  (resp_data),
        .resp_err   (resp_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic add_row(input lsu_pkg::mem_op_e op, input logic [31:0] base,
                           input logic [31:0] imm, input logic [31:0] wdata);
        op_tab[row_count]    = op;
        base_tab[row_count]  = base;
        imm_tab[row_count]   = imm;
        wdata_tab[row_count] = wdata;
        rd_tab[row_count]    = 6'(row_count + 1);
        row_count++;
    endtask

    // little-endian byte model, misaligned accesses leave it untouched
    task automatic build_expected();
        logic [31:0] addr;
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        logic        err;
        for (int i = 0; i < NUM_ROWS; i++) begin
            addr = base_tab[i] + imm_tab[i];
            a    = addr[9:0];
            b    = model_mem[a];
            h    = {model_mem[a + 10'd1], model_mem[a]};
            w    = {model_mem[a + 10'd3], model_mem[a + 10'd2], h};
            case (op_tab[i])
                lsu_pkg::LDH, lsu_pkg::LDHU, lsu_pkg::STH: err = addr[0];
                lsu_pkg::LDW, lsu_pkg::STW:                err = |addr[1:0];
                default:                                   err = 1'b0;
            endcase
            exp_err_tab[i]  = err;
            exp_data_tab[i] = 32'd0;
            if (!err) begin
                case (op_tab[i])
                    lsu_pkg::LDB:  exp_data_tab[i] = {{24{b[7]}}, b};
                    lsu_pkg::LDH:  exp_data_tab[i] = {{16{h[15]}}, h};
                    lsu_pkg::LDW:  exp_data_tab[i] = w;
                    lsu_pkg::LDBU: exp_data_tab[i] = {24'd0, b};
                    lsu_pkg::LDHU: exp_data_tab[i] = {16'd0, h};
                    lsu_pkg::STB:  model_mem[a] = wdata_tab[i][7:0];
                    lsu_pkg::STH: begin
                        model_mem[a]         = wdata_tab[i][7:0];
                        model_mem[a + 10'd1] = wdata_tab[i][15:8];
                    end
                    default: begin
                        for (int k = 0; k < 4; k++) begin
                            model_mem[a + 10'(k)] = wdata_tab[i][8*k +: 8];
                        end
                    end
                endcase
            end
        end
    endtask

    task automatic apply_row(input int i);
        int   gap;
        logic row_ok;
        lfsr_state = lfsr_next(lfsr_state);
        gap        = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap        = gap * 2 + lfsr_state[0];
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #2;
        req_op    = op_tab[i];
        req_base  = base_tab[i];
        req_imm   = imm_tab[i];
        req_wdata = wdata_tab[i];
        req_rd    = rd_tab[i];
        req_valid = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk); // accepted here
        #2;
        req_valid = 1'b0;
        do @(negedge clk); while (!resp_valid);
        row_ok = 1'b1;
        if (resp_rd !== rd_tab[i]) begin
            $display("FAIL row %0d resp_rd got %h expected %h", i, resp_rd, rd_tab[i]);
            row_ok = 1'b0;
        end
        if (resp_data !== exp_data_tab[i]) begin
            $display("FAIL row %0d resp_data got %h expected %h", i, resp_data,
                     exp_data_tab[i]);
            row_ok = 1'b0;
        end
        if (resp_err !== exp_err_tab[i]) begin
            $display("FAIL row %0d resp_err got %h expected %h", i, resp_err,
                     exp_err_tab[i]);
            row_ok = 1'b0;
        end
        if (row_ok) pass_count++;
        else fail_count++;
        $display("row %0d %s addr %h: %s", i, op_tab[i].name(), base_tab[i] + imm_tab[i],
                 row_ok ? "ok" : "mismatch");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a request or response never arrived",
                 cycle_count);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_op     = lsu_pkg::LDW;
        req_base   = 32'd0;
        req_imm    = 32'd0;
        req_wdata  = 32'd0;
        req_rd     = 6'd0;
        lfsr_state = 32'h8e66;
        row_count  = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < 1024; i++) model_mem[i] = 8'h00;

        add_row(lsu_pkg::STW,  32'h100, 32'h0, 32'hdeadbeef); // word store then load
        add_row(lsu_pkg::LDW,  32'h100, 32'h0, 32'h0);
        add_row(lsu_pkg::STB,  32'h200, 32'h0, 32'h12345685); // lanes of one word
        add_row(lsu_pkg::STB,  32'h200, 32'h1, 32'h0000007f);
        add_row(lsu_pkg::STH,  32'h200, 32'h2, 32'h9999c3a1);
        add_row(lsu_pkg::LDW,  32'h200, 32'h0, 32'h0);
        add_row(lsu_pkg::LDB,  32'h200, 32'h0, 32'h0);
        add_row(lsu_pkg::LDBU, 32'h200, 32'h0, 32'h0);
        add_row(lsu_pkg::LDB,  32'h200, 32'h1, 32'h0);
        add_row(lsu_pkg::LDH,  32'h200, 32'h2, 32'h0);
        add_row(lsu_pkg::LDHU, 32'h200, 32'h2, 32'h0);
        add_row(lsu_pkg::LDBU, 32'h200, 32'h3, 32'h0);
        add_row(lsu_pkg::LDH,  32'h100, 32'h1, 32'h0);        // misaligned group
        add_row(lsu_pkg::LDW,  32'h100, 32'h2, 32'h0);
        add_row(lsu_pkg::STH,  32'h100, 32'h3, 32'h00001234);
        add_row(lsu_pkg::STW,  32'h100, 32'h1, 32'h55555555);
        add_row(lsu_pkg::LDW,  32'h100, 32'h0, 32'h0);
        add_row(lsu_pkg::LDW,  32'h300, 32'h0, 32'h0);        // fill, then store hit
        add_row(lsu_pkg::STH,  32'h300, 32'h0, 32'h0000beef);
        add_row(lsu_pkg::LDW,  32'h304, 32'hfffffffc, 32'h0);
        add_row(lsu_pkg::STW,  32'h080, 32'h0, 32'h11112222); // same index, 64 apart
        add_row(lsu_pkg::STW,  32'h0c0, 32'h0, 32'h33334444);
        add_row(lsu_pkg::LDW,  32'h080, 32'h0, 32'h0);
        add_row(lsu_pkg::LDW,  32'h0c0, 32'h0, 32'h0);
        add_row(lsu_pkg::LDW,  32'h080, 32'h0, 32'h0);
        add_row(lsu_pkg::LDH,  32'h0c0, 32'h2, 32'h0);
        build_expected();

        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
            $display("FAIL reset req_ready %h resp_valid %h expected 1 and 0", req_ready,
                     resp_valid);
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("reset state checked");

        for (int i = 0; i < NUM_ROWS; i++) apply_row(i);

        $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/lsu_pkg.sv
source/dcache_if.sv
source/mem_stage.sv
source/dcache.sv
source/wb_ram.sv
source/lsu_top.sv
dv/tb_lsu_top.sv
